// File: ipod_player.f
+incdir+verilog
verilog/ipod_pkg.sv
verilog/kbd_command_decode.sv
verilog/sample_rate_timer.sv
verilog/flash_fetch.sv
verilog/sample_unpack.sv
verilog/rate_hex_display.sv
verilog/ipod_player.sv
testbench/tb_ipod_player.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ipod_player testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f ipod_player.f \
  --top-module tb_ipod_player \
  -o sim_ipod_player

# The simulator exits non-zero on an error, so the log is searched instead
./obj_dir/sim_ipod_player > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation passed"

// File: testbench/tb_ipod_player.sv
`timescale 1ns/1ps
`include "ipod_params.svh"

module tb_ipod_player
  import ipod_pkg::*;
();

  // Enough bytes for every test step, each at the slowest rate
  localparam int expected_samples = 160;
  localparam int watchdog_cycles  = expected_samples * (`DIV_MAX + 20);

  localparam speed_evt_t speed_up_evt    = 3'b100;
  localparam speed_evt_t speed_down_evt  = 3'b010;
  localparam speed_evt_t speed_reset_evt = 3'b001;

  // Active low segments, gfedcba
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic       CLK_50M;
  logic       rst;
  logic       kbd_valid;
  logic [7:0] kbd_ascii;
  speed_evt_t speed_evt;
  logic       flash_req_valid;
  flash_req_t flash_req;
  logic       flash_req_ready;
  logic       flash_rsp_valid;
  flash_rsp_t flash_rsp;
  logic       audio_valid;
  audio_t     audio;
  logic [6:0] hex0;
  logic [6:0] hex1;
  logic [6:0] hex2;
  logic [6:0] hex3;
  logic [6:0] hex4;
  logic [6:0] hex5;

  integer seed = 12030;
  int     errors = 0;

  // Reference play state
  logic [`FLASH_ADDR_W-1:0] ref_addr = '0;
  logic ref_half = 1'b0;
  logic ref_rev = 1'b0;
  logic tb_rev = 1'b0;
  logic wrapped_back = 1'b0;
  logic paused = 1'b0;
  int   audio_count = 0;
  int   exp_div = `DIV_DEFAULT;

  // Flash model state
  logic bp_mode = 1'b0;
  logic req_taken = 1'b0;
  logic rsp_pending = 1'b0;
  logic [`FLASH_ADDR_W-1:0] taken_addr;
  logic [`FLASH_ADDR_W-1:0] rsp_addr;
  int   rsp_wait = 0;
  int   run_left = 0;

  ipod_player UUT (
    .CLK_50M         (CLK_50M),
    .rst             (rst),
    .kbd_valid       (kbd_valid),
    .kbd_ascii       (kbd_ascii),
    .speed_evt       (speed_evt),
    .flash_req_valid (flash_req_valid),
    .flash_req       (flash_req),
    .flash_req_ready (flash_req_ready),
    .flash_rsp_valid (flash_rsp_valid),
    .flash_rsp       (flash_rsp),
    .audio_valid     (audio_valid),
    .audio           (audio),
    .hex0            (hex0),
    .hex1            (hex1),
    .hex2            (hex2),
    .hex3            (hex3),
    .hex4            (hex4),
    .hex5            (hex5)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ==========================================================================
  // Reference model and checks
  // ==========================================================================

  // High half is the inverted address, low half the address
  function automatic logic [`FLASH_DATA_W-1:0] flash_word(input logic [`FLASH_ADDR_W-1:0] addr);
    flash_word = {~addr[15:0], addr[15:0]};
  endfunction

  function automatic audio_t expected_audio(input logic [`FLASH_ADDR_W-1:0] addr,
                                            input logic half, input logic rev);
    logic [`FLASH_DATA_W-1:0] data;
    sample_t                  sample;
    data = flash_word(addr);
    if (rev)
      sample = (half == 1'b0) ? data[31:16] : data[15:0];
    else
      sample = (half == 1'b0) ? data[15:0] : data[31:16];
    expected_audio = sample[15:8];
  endfunction

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_audio(input audio_t got, input audio_t exp);
    if (got !== exp)
      abort_run($sformatf("FAILED audio: got %h expected %h (addr %h half %0d)",
                          got, exp, ref_addr, ref_half));
  endtask

  task automatic check_div(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAILED div_count: got %h expected %h", got, exp));
  endtask

  task automatic check_hex(input logic [15:0] count);
    logic [23:0] value;
    logic [6:0]  got [6];
    logic [6:0]  exp;
    value  = {8'h00, count};
    got[0] = hex0;
    got[1] = hex1;
    got[2] = hex2;
    got[3] = hex3;
    got[4] = hex4;
    got[5] = hex5;
    for (int i = 0; i < 6; i++)
    begin
      exp = seg_table[value[i*4 +: 4]];
      if (got[i] !== exp)
        abort_run($sformatf("FAILED hex%0d: got %h expected %h", i, got[i], exp));
    end
  endtask

  // Compare every audio byte, then step the reference
  always @(posedge CLK_50M)
  begin
    if (!rst && audio_valid)
    begin
      if (paused)
        abort_run("Audio came out while playback was paused");
      check_audio(audio, expected_audio(ref_addr, ref_half, ref_rev));
      audio_count++;
      if (ref_half == 1'b0)
        ref_half = 1'b1;
      else
      begin
        ref_half = 1'b0;
        if (ref_rev)
        begin
          if (ref_addr == '0)
          begin
            ref_addr     = `LAST_ADDR;
            wrapped_back = 1'b1;
          end
          else
            ref_addr = ref_addr - 1;
        end
        else
          ref_addr = (ref_addr == `LAST_ADDR) ? '0 : ref_addr + 1;
        // Next word takes the direction in force now
        ref_rev = tb_rev;
      end
    end
  end

  // ==========================================================================
  // Flash model
  // ==========================================================================

  always @(posedge CLK_50M)
  begin
    if (!rst && flash_req_valid && flash_req_ready)
    begin
      if (req_taken || rsp_pending)
        abort_run("A second flash request was issued while one was outstanding");
      req_taken  = 1'b1;
      taken_addr = flash_req.addr;
    end
  end

  always @(negedge CLK_50M)
  begin
    flash_rsp_valid = 1'b0;
    if (req_taken)
    begin
      req_taken   = 1'b0;
      rsp_pending = 1'b1;
      rsp_addr    = taken_addr;
      rsp_wait    = $unsigned($random(seed)) % 4;
    end
    if (rsp_pending)
    begin
      if (rsp_wait == 0)
      begin
        flash_rsp_valid = 1'b1;
        flash_rsp.data  = flash_word(rsp_addr);
        rsp_pending     = 1'b0;
      end
      else
        rsp_wait--;
    end
    if (bp_mode)
    begin
      // Long low stretches with short ready windows
      if (run_left == 0)
      begin
        flash_req_ready = !flash_req_ready;
        if (flash_req_ready)
          run_left = $unsigned($random(seed)) % 3;
        else
          run_left = 200 + $unsigned($random(seed)) % 2300;
      end
      else
        run_left--;
    end
    else
      flash_req_ready = ($random(seed) & 3) != 0;
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic restart_reference();
    ref_addr = tb_rev ? `LAST_ADDR : '0;
    ref_rev  = tb_rev;
    ref_half = 1'b0;
  endtask

  task automatic press_key(input logic [7:0] code);
    @(negedge CLK_50M);
    kbd_valid = 1'b1;
    kbd_ascii = code;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    case (code)
      `KEY_FWD:     tb_rev = 1'b0;
      `KEY_BWD:     tb_rev = 1'b1;
      `KEY_RESTART: restart_reference();
      default:      ;
    endcase
  endtask

  task automatic wait_audio(input int count);
    int target;
    target = audio_count + count;
    while (audio_count < target)
      @(negedge CLK_50M);
  endtask

  // Returns just after a first half, long before the next tick
  task automatic wait_mid_word();
    int  last_count;
    logic seen;
    last_count = audio_count;
    seen       = 1'b0;
    while (!seen)
    begin
      @(negedge CLK_50M);
      if (audio_count != last_count)
      begin
        last_count = audio_count;
        seen       = (ref_half == 1'b1);
      end
    end
  endtask

  task automatic send_speed(input speed_evt_t evt);
    @(negedge CLK_50M);
    speed_evt = evt;
    @(negedge CLK_50M);
    speed_evt = '0;
    if (evt.reset)
      exp_div = `DIV_DEFAULT;
    else if (evt.up)
      exp_div = (exp_div - `DIV_STEP < `DIV_MIN) ? `DIV_MIN : exp_div - `DIV_STEP;
    else if (evt.down)
      exp_div = (exp_div + `DIV_STEP > `DIV_MAX) ? `DIV_MAX : exp_div + `DIV_STEP;
    check_div(UUT.div_count, exp_div[15:0]);
    @(negedge CLK_50M);
    check_hex(exp_div[15:0]);
  endtask

  initial
  begin
    #(watchdog_cycles * 20);
    abort_run("Timeout: the tests did not finish in the expected time");
  end

  initial
  begin
    CLK_50M         = 1'b0;
    rst             = 1'b1;
    kbd_valid       = 1'b0;
    kbd_ascii       = 8'h00;
    speed_evt       = '0;
    flash_req_ready = 1'b0;
    flash_rsp_valid = 1'b0;
    flash_rsp       = '0;
    repeat (5) @(negedge CLK_50M);
    rst = 1'b0;
    @(negedge CLK_50M);
    if (flash_req_valid !== 1'b0)
      abort_run($sformatf("FAILED flash_req_valid: got %h expected %h",
                          flash_req_valid, 1'b0));
    if (audio_valid !== 1'b0)
      abort_run($sformatf("FAILED audio_valid: got %h expected %h", audio_valid, 1'b0));
    check_div(UUT.div_count, `DIV_DEFAULT);
    check_hex(`DIV_DEFAULT);

    // Forward play, and an unknown key changes nothing
    press_key(`KEY_PLAY);
    wait_audio(20);
    press_key(8'h58);
    wait_audio(20);

    // Pause holds the position
    wait_mid_word();
    press_key(`KEY_PAUSE);
    @(negedge CLK_50M);
    paused = 1'b1;
    repeat (3000) @(negedge CLK_50M);
    paused = 1'b0;
    press_key(`KEY_PLAY);
    wait_audio(6);

    // Backward from the top, then forward from zero
    wait_mid_word();
    press_key(`KEY_BWD);
    press_key(`KEY_RESTART);
    wait_audio(8);
    wait_mid_word();
    press_key(`KEY_FWD);
    press_key(`KEY_RESTART);
    wait_audio(6);

    // Turn around mid stream and run through address 0
    wait_mid_word();
    wrapped_back = 1'b0;
    press_key(`KEY_BWD);
    while (!wrapped_back)
      @(negedge CLK_50M);
    wait_audio(4);

    // Speed clamps at both ends
    repeat (12) send_speed(speed_up_evt);
    repeat (100) send_speed(speed_down_evt);
    repeat (3) send_speed(speed_up_evt);
    send_speed(speed_reset_evt);

    // Heavy flash back-pressure
    bp_mode = 1'b1;
    wait_audio(30);
    bp_mode = 1'b0;

    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: verilog/ipod_player.sv
`timescale 1ns/1ps

module ipod_player
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  // Keyboard
  input  logic       kbd_valid,
  input  logic [7:0] kbd_ascii,
  // Speed control pulses
  input  speed_evt_t speed_evt,
  // Flash read port
  output logic       flash_req_valid,
  output flash_req_t flash_req,
  input  logic       flash_req_ready,
  input  logic       flash_rsp_valid,
  input  flash_rsp_t flash_rsp,
  // Audio out
  output logic       audio_valid,
  output audio_t     audio,
  // Seven segment display
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  play_cmd_t   cmd;
  logic        sample_tick;
  logic [15:0] div_count;
  logic        word_valid;
  logic        word_ready;
  flash_rsp_t  word;

  // ========================================================================
  // Decode
  // ========================================================================

  kbd_command_decode u_decode (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .kbd_valid (kbd_valid),
    .kbd_ascii (kbd_ascii),
    .cmd       (cmd)
  );

  // ========================================================================
  // Execute
  // ========================================================================

  sample_rate_timer u_timer (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_evt   (speed_evt),
    .sample_tick (sample_tick),
    .div_count   (div_count)
  );

  flash_fetch u_fetch (
    .CLK_50M         (CLK_50M),
    .rst             (rst),
    .cmd             (cmd),
    .flash_req_valid (flash_req_valid),
    .flash_req       (flash_req),
    .flash_req_ready (flash_req_ready),
    .flash_rsp_valid (flash_rsp_valid),
    .flash_rsp       (flash_rsp),
    .word_valid      (word_valid),
    .word            (word),
    .word_ready      (word_ready)
  );

  // ========================================================================
  // Result
  // ========================================================================

  sample_unpack u_unpack (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .cmd         (cmd),
    .sample_tick (sample_tick),
    .word_valid  (word_valid),
    .word        (word),
    .word_ready  (word_ready),
    .audio_valid (audio_valid),
    .audio       (audio)
  );

  rate_hex_display u_display (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .div_count (div_count),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

endmodule

// File: verilog/rate_hex_display.sv
`timescale 1ns/1ps

module rate_hex_display (
  input  logic        CLK_50M,
  input  logic        rst,
  input  logic [15:0] div_count,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic [23:0] count_q;

  // Active low segments in gfedcba order
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'hA: seg7 = 7'h08;
      4'hB: seg7 = 7'h03;
      4'hC: seg7 = 7'h46;
      4'hD: seg7 = 7'h21;
      4'hE: seg7 = 7'h06;
      default: seg7 = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      count_q <= '0;
    else
      count_q <= {8'h00, div_count};
  end

  // Upper two digits always read 0
  assign hex0 = seg7(count_q[3:0]);
  assign hex1 = seg7(count_q[7:4]);
  assign hex2 = seg7(count_q[11:8]);
  assign hex3 = seg7(count_q[15:12]);
  assign hex4 = seg7(count_q[19:16]);
  assign hex5 = seg7(count_q[23:20]);

endmodule

// File: verilog/sample_unpack.sv
`timescale 1ns/1ps
`include "ipod_params.svh"

module sample_unpack
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  play_cmd_t  cmd,
  input  logic       sample_tick,
  input  logic       word_valid,
  input  flash_rsp_t word,
  output logic       word_ready,
  output logic       audio_valid,
  output audio_t     audio
);

  logic       held;
  // 0 for the first half played, 1 for the second
  logic       half;
  // Play order fixed when the word is taken
  logic       rev_order;
  flash_rsp_t data;
  sample_t    cur_sample;

  assign word_ready = !held;

  // Forward plays low then high, backward high then low
  assign cur_sample = (half ^ rev_order) ? data.data[31:16] : data.data[15:0];

  // ========================================================================
  // Word hold and sample sequencing
  // ========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      held        <= 1'b0;
      half        <= 1'b0;
      rev_order   <= 1'b0;
      audio_valid <= 1'b0;
    end
    else if (cmd.restart)
    begin
      held        <= 1'b0;
      half        <= 1'b0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;
      if (word_valid && word_ready)
      begin
        held      <= 1'b1;
        half      <= 1'b0;
        rev_order <= cmd.reverse;
      end
      else if (sample_tick && cmd.playing && held)
      begin
        audio_valid <= 1'b1;
        if (half)
          held <= 1'b0;
        else
          half <= 1'b1;
      end
      // A tick with nothing held is simply skipped
    end
  end

  // Payload registers
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid && word_ready)
      data <= word;
    if (sample_tick && held)
      audio <= audio_t'(cur_sample[`SAMPLE_W-1 -: `AUDIO_W]);
  end

endmodule

// File: verilog/flash_fetch.sv
`timescale 1ns/1ps
`include "ipod_params.svh"

module flash_fetch
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  play_cmd_t  cmd,
  output logic       flash_req_valid,
  output flash_req_t flash_req,
  input  logic       flash_req_ready,
  input  logic       flash_rsp_valid,
  input  flash_rsp_t flash_rsp,
  output logic       word_valid,
  output flash_rsp_t word,
  input  logic       word_ready
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

  state_t                   state;
  logic [`FLASH_ADDR_W-1:0] addr;
  logic [`FLASH_ADDR_W-1:0] start_addr;
  logic [`FLASH_ADDR_W-1:0] step_addr;
  // Response in flight belongs to a cancelled fetch
  logic                     drop;

  assign flash_req_valid = (state == REQ);
  assign start_addr      = cmd.reverse ? `LAST_ADDR : '0;

  // Next word in play direction, wraps at both ends
  always_comb
  begin
    if (cmd.reverse)
      step_addr = (addr == '0) ? `LAST_ADDR : addr - 1'b1;
    else
      step_addr = (addr == `LAST_ADDR) ? '0 : addr + 1'b1;
  end

  // ========================================================================
  // Fetch FSM
  // ========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state      <= IDLE;
      addr       <= '0;
      drop       <= 1'b0;
      word_valid <= 1'b0;
    end
    else if (cmd.restart)
    begin
      addr       <= start_addr;
      word_valid <= 1'b0;
      case (state)
        IDLE: state <= cmd.playing ? REQ : IDLE;
        REQ:
        begin
          // Request must stay stable, so finish it and drop the data
          drop <= 1'b1;
          if (flash_req_ready)
            state <= WAIT;
        end
        default:
        begin
          drop <= !flash_rsp_valid;
          if (flash_rsp_valid)
            state <= IDLE;
        end
      endcase
    end
    else
    begin
      if (word_valid && word_ready)
      begin
        word_valid <= 1'b0;
        addr       <= step_addr;
      end
      case (state)
        IDLE:
        begin
          if (!word_valid && word_ready && cmd.playing)
            state <= REQ;
        end
        REQ:
        begin
          if (flash_req_ready)
            state <= WAIT;
        end
        default:
        begin
          if (flash_rsp_valid)
          begin
            state      <= IDLE;
            drop       <= 1'b0;
            word_valid <= !drop;
          end
        end
      endcase
    end
  end

  // Address is latched while idle and held through the request
  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE)
      flash_req.addr <= cmd.restart ? start_addr : addr;
    if (state == WAIT && flash_rsp_valid)
      word <= flash_rsp;
  end

endmodule

// File: verilog/sample_rate_timer.sv
`timescale 1ns/1ps
`include "ipod_params.svh"

module sample_rate_timer
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  speed_evt_t  speed_evt,
  output logic        sample_tick,
  output logic [15:0] div_count
);

  logic [15:0] tick_cnt;

  // ========================================================================
  // Divider count
  // ========================================================================

  // Smaller count means faster playback
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      div_count <= `DIV_DEFAULT;
    end
    else if (speed_evt.reset)
    begin
      div_count <= `DIV_DEFAULT;
    end
    else if (speed_evt.up)
    begin
      if (div_count >= `DIV_MIN + `DIV_STEP)
        div_count <= div_count - `DIV_STEP;
      else
        div_count <= `DIV_MIN;
    end
    else if (speed_evt.down)
    begin
      if (div_count + `DIV_STEP <= `DIV_MAX)
        div_count <= div_count + `DIV_STEP;
      else
        div_count <= `DIV_MAX;
    end
  end

  // ========================================================================
  // Tick generator
  // ========================================================================

  // Counts 0..div_count so the period is div_count + 1 cycles
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= div_count)
    begin
      // Greater-than also covers a count that just shrank
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

// File: verilog/kbd_command_decode.sv
`timescale 1ns/1ps
`include "ipod_params.svh"

module kbd_command_decode
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic       kbd_valid,
  input  logic [7:0] kbd_ascii,
  output play_cmd_t  cmd
);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      cmd <= '0;
    end
    else
    begin
      // Restart only lasts one cycle
      cmd.restart <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          `KEY_PLAY:
          begin
            cmd.playing <= 1'b1;
          end
          `KEY_PAUSE:
          begin
            cmd.playing <= 1'b0;
          end
          `KEY_FWD:
          begin
            cmd.reverse <= 1'b0;
          end
          `KEY_BWD:
          begin
            cmd.reverse <= 1'b1;
          end
          `KEY_RESTART:
          begin
            cmd.restart <= 1'b1;
          end
          default:
          begin
            // Unknown keys leave the state alone
            cmd.restart <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

// File: verilog/ipod_pkg.sv
`include "ipod_params.svh"

package ipod_pkg;

  // ========================================================================
  // Player control
  // ========================================================================

  // Play state from the keyboard decoder
  typedef struct packed {
    logic playing;
    logic reverse;
    // Single cycle pulse
    logic restart;
  } play_cmd_t;

  // Speed events, at most one high per cycle
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_evt_t;

  // ========================================================================
  // Flash port
  // ========================================================================

  typedef struct packed {
    logic [`FLASH_ADDR_W-1:0] addr;
  } flash_req_t;

  typedef struct packed {
    logic [`FLASH_DATA_W-1:0] data;
  } flash_rsp_t;

  // Audio samples
  typedef logic [`SAMPLE_W-1:0] sample_t;
  typedef logic signed [`AUDIO_W-1:0] audio_t;

endpackage

// File: verilog/ipod_params.svh
`ifndef IPOD_PARAMS_SVH
`define IPOD_PARAMS_SVH

// ==========================================================================
// Data path widths
// ==========================================================================

`define FLASH_ADDR_W 23
`define FLASH_DATA_W 32
`define SAMPLE_W     16
`define AUDIO_W      8

// Last word of the sample region in flash
`define LAST_ADDR    23'h7FFFF

// ==========================================================================
// Sample divider
// ==========================================================================

// Default count gives roughly 44 kHz from the 50 MHz clock
`define DIV_DEFAULT  16'd1136
`define DIV_STEP     16'd100
`define DIV_MIN      16'd136
`define DIV_MAX      16'd9936

// ==========================================================================
// Keyboard command codes (upper case ASCII)
// ==========================================================================

`define KEY_PLAY     8'h45
`define KEY_PAUSE    8'h44
`define KEY_FWD      8'h46
`define KEY_BWD      8'h42
`define KEY_RESTART  8'h52

`endif
